/* all.f */
+incdir+include
hw/cpu_pkg.sv
hw/alu.sv
hw/cpu_datapath.sv
hw/cpu_control.sv
hw/cpu_top.sv
testbench/tb_cpu.sv

/* hw/alu.sv */
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::data_t   a,
    input  cpu_pkg::data_t   b,
    output cpu_pkg::data_t   f
);

    // all results wrap to the word width
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: begin
                f = a + b;
            end
            cpu_pkg::ALU_SUB: begin
                f = a - b;
            end
            cpu_pkg::ALU_MUL: begin
                f = a * b;
            end
            default: begin
                f = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`default_nettype none

`include "cpu_config.svh"

module cpu_control (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::data_t      mdr,
    output cpu_pkg::dp_ctrl_t   dp_ctrl,
    output logic                halted,
    output cpu_pkg::addr_t      pc
);

    typedef enum logic [3:0] {
        S_FETCH_MAR,
        S_FETCH_MDR,
        S_FETCH_IR,
        S_OP_MAR,
        S_OP_MDR,
        S_OP_PTR,
        S_OP_MDR2,
        S_XEA,
        S_EXEC,
        S_WRITE,
        S_OUT,
        S_HALT
    } state_e;

    typedef enum logic [1:0] {
        F_X,
        F_Y,
        F_Z
    } field_sel_e;

    state_e                  state_q, state_d;
    state_e                  after_state;
    field_sel_e              fsel_q, fsel_d;
    field_sel_e              after_fsel, stop_sel;
    cpu_pkg::instr_t         ir_q, fetched;
    cpu_pkg::addr_t          pc_q;
    cpu_pkg::operand_field_t cur_field;
    cpu_pkg::out_src_e       out_src;
    cpu_pkg::alu_op_e        alu_op;
    logic                    halted_q;
    logic                    is_mov, is_write_op, is_show_op;
    logic                    addr_only, stop_done;
    logic [2:0]              stop_mask;

    assign fetched = cpu_pkg::instr_t'(mdr);

    assign is_mov = (ir_q.opcode == cpu_pkg::OP_MOV);
    assign is_write_op = is_mov || (ir_q.opcode == cpu_pkg::OP_ADD) ||
                         (ir_q.opcode == cpu_pkg::OP_SUB) || (ir_q.opcode == cpu_pkg::OP_MUL);
    assign is_show_op = (ir_q.opcode == cpu_pkg::OP_OUT) || (ir_q.opcode == cpu_pkg::OP_STOP);

    // destination of a write is walked as an address, never read as a value
    assign addr_only = is_write_op && (fsel_q == F_X);

    always_comb begin
        case (fsel_q)
            F_Y: begin
                cur_field = ir_q.y;
                out_src = cpu_pkg::OUT_Y;
            end
            F_Z: begin
                cur_field = ir_q.z;
                out_src = cpu_pkg::OUT_Z;
            end
            default: begin
                cur_field = ir_q.x;
                out_src = cpu_pkg::OUT_MDR;
            end
        endcase
    end

    always_comb begin
        case (ir_q.opcode)
            cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_MUL: alu_op = cpu_pkg::ALU_MUL;
            default: alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    // STOP field walk: bit 2 is X, bit 0 is Z, zero addresses drop out
    always_comb begin
        if (state_q == S_FETCH_IR) begin
            stop_mask = {fetched.x.addr != '0, fetched.y.addr != '0, fetched.z.addr != '0};
        end else begin
            stop_mask = {ir_q.x.addr != '0, ir_q.y.addr != '0, ir_q.z.addr != '0};
            case (fsel_q)
                F_X: stop_mask = stop_mask & 3'b011;
                F_Y: stop_mask = stop_mask & 3'b001;
                default: stop_mask = 3'b000;
            endcase
        end
        stop_done = (stop_mask == 3'b000);
        if (stop_mask[2]) begin
            stop_sel = F_X;
        end else if (stop_mask[1]) begin
            stop_sel = F_Y;
        end else begin
            stop_sel = F_Z;
        end
    end

    // where to go once the current field is resolved
    always_comb begin
        after_fsel = fsel_q;
        if (is_show_op) begin
            after_state = S_OUT;
        end else if (fsel_q == F_X) begin
            after_state = S_OP_MAR;
            after_fsel = F_Y;
        end else if (fsel_q == F_Y && !is_mov) begin
            after_state = S_OP_MAR;
            after_fsel = F_Z;
        end else begin
            after_state = S_EXEC;
        end
    end

    always_comb begin
        dp_ctrl = '0;
        dp_ctrl.field_addr = cur_field.addr;
        dp_ctrl.pc = pc_q;
        dp_ctrl.alu_op = alu_op;
        dp_ctrl.wdata_src = is_mov ? cpu_pkg::WDATA_Y : cpu_pkg::WDATA_ALU;
        dp_ctrl.out_src = out_src;
        state_d = state_q;
        fsel_d = fsel_q;

        case (state_q)
            S_FETCH_MAR: begin
                dp_ctrl.mar_ld = 1'b1;
                dp_ctrl.mar_src = cpu_pkg::MAR_SRC_PC;
                state_d = S_FETCH_MDR;
            end
            S_FETCH_MDR: begin
                dp_ctrl.mdr_ld = 1'b1;
                state_d = S_FETCH_IR;
            end
            S_FETCH_IR: begin
                // decode straight from the MDR while the IR loads
                case (fetched.opcode)
                    cpu_pkg::OP_MOV, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                    cpu_pkg::OP_MUL, cpu_pkg::OP_OUT: begin
                        fsel_d = F_X;
                        state_d = S_OP_MAR;
                    end
                    cpu_pkg::OP_STOP: begin
                        fsel_d = stop_sel;
                        state_d = stop_done ? S_HALT : S_OP_MAR;
                    end
                    default: begin
                        state_d = S_FETCH_MAR;
                    end
                endcase
            end
            S_OP_MAR: begin
                dp_ctrl.mar_ld = 1'b1;
                dp_ctrl.mar_src = cpu_pkg::MAR_SRC_FIELD;
                state_d = (addr_only && !cur_field.ind) ? S_XEA : S_OP_MDR;
            end
            S_OP_MDR: begin
                dp_ctrl.mdr_ld = 1'b1;
                if (cur_field.ind) begin
                    state_d = S_OP_PTR;
                end else begin
                    dp_ctrl.y_ld = (fsel_q == F_Y);
                    dp_ctrl.z_ld = (fsel_q == F_Z);
                    state_d = after_state;
                    fsel_d = after_fsel;
                end
            end
            S_OP_PTR: begin
                dp_ctrl.mar_ld = 1'b1;
                dp_ctrl.mar_src = cpu_pkg::MAR_SRC_MDR;
                state_d = addr_only ? S_XEA : S_OP_MDR2;
            end
            S_OP_MDR2: begin
                dp_ctrl.mdr_ld = 1'b1;
                dp_ctrl.y_ld = (fsel_q == F_Y);
                dp_ctrl.z_ld = (fsel_q == F_Z);
                state_d = after_state;
                fsel_d = after_fsel;
            end
            S_XEA: begin
                dp_ctrl.xea_ld = 1'b1;
                state_d = after_state;
                fsel_d = after_fsel;
            end
            S_EXEC: begin
                // also latches the write data in the datapath
                dp_ctrl.mar_ld = 1'b1;
                dp_ctrl.mar_src = cpu_pkg::MAR_SRC_XEA;
                state_d = S_WRITE;
            end
            S_WRITE: begin
                dp_ctrl.we = 1'b1;
                state_d = S_FETCH_MAR;
            end
            S_OUT: begin
                dp_ctrl.out_valid = 1'b1;
                if (ir_q.opcode == cpu_pkg::OP_STOP) begin
                    fsel_d = stop_sel;
                    state_d = stop_done ? S_HALT : S_OP_MAR;
                end else begin
                    state_d = S_FETCH_MAR;
                end
            end
            S_HALT: begin
                state_d = S_HALT;
            end
            default: begin
                state_d = S_FETCH_MAR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_FETCH_MAR;
            fsel_q <= F_X;
            ir_q <= '0;
            pc_q <= cpu_pkg::addr_t'(`CPU_RESET_PC);
            halted_q <= 1'b0;
        end else begin
            state_q <= state_d;
            fsel_q <= fsel_d;
            if (state_q == S_FETCH_IR) begin
                ir_q <= fetched;
            end
            if (state_q == S_FETCH_MDR) begin
                pc_q <= pc_q + 1'b1;
            end
            // rises a cycle after the last STOP output pulse
            if (state_q == S_HALT) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign halted = halted_q;
    assign pc = pc_q;

endmodule

`default_nettype wire

/* hw/cpu_datapath.sv */
`default_nettype none

`include "cpu_config.svh"

module cpu_datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::dp_ctrl_t   dp_ctrl,
    input  cpu_pkg::data_t      mem_rdata,
    output cpu_pkg::mem_req_t   mem_req,
    output cpu_pkg::data_t      mdr,
    output cpu_pkg::data_t      out_data,
    output logic                out_valid
);

    cpu_pkg::addr_t mar_q, mar_d;
    cpu_pkg::addr_t xea_q;
    cpu_pkg::data_t mdr_q;
    cpu_pkg::data_t y_q, z_q;
    cpu_pkg::data_t wdata_q, wdata_d;
    cpu_pkg::data_t alu_f;
    cpu_pkg::data_t out_d, out_data_q;
    logic           out_valid_q;
    logic           wdata_ld;

    alu u_alu (
        .op (dp_ctrl.alu_op),
        .a  (y_q),
        .b  (z_q),
        .f  (alu_f)
    );

    always_comb begin
        case (dp_ctrl.mar_src)
            cpu_pkg::MAR_SRC_PC: mar_d = dp_ctrl.pc;
            cpu_pkg::MAR_SRC_FIELD: mar_d = cpu_pkg::addr_t'(dp_ctrl.field_addr);
            // indirect pointer, low bits of the word just read
            cpu_pkg::MAR_SRC_MDR: mar_d = mdr_q[`CPU_ADDR_WIDTH-1:0];
            default: mar_d = xea_q;
        endcase
    end

    // write data is captured when the MAR takes the destination address
    assign wdata_ld = dp_ctrl.mar_ld && (dp_ctrl.mar_src == cpu_pkg::MAR_SRC_XEA);
    assign wdata_d = (dp_ctrl.wdata_src == cpu_pkg::WDATA_Y) ? y_q : alu_f;

    always_comb begin
        case (dp_ctrl.out_src)
            cpu_pkg::OUT_Y: out_d = y_q;
            cpu_pkg::OUT_Z: out_d = z_q;
            default: out_d = mdr_q;
        endcase
    end

    // MAR drives the memory address, so it holds the reset PC
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar_q <= cpu_pkg::addr_t'(`CPU_RESET_PC);
        end else if (dp_ctrl.mar_ld) begin
            mar_q <= mar_d;
        end
    end

    always_ff @(posedge clk) begin
        if (dp_ctrl.mdr_ld) begin
            mdr_q <= mem_rdata;
        end
        // X effective address ends up in the MAR first
        if (dp_ctrl.xea_ld) begin
            xea_q <= mar_q;
        end
        if (dp_ctrl.y_ld) begin
            y_q <= mem_rdata;
        end
        if (dp_ctrl.z_ld) begin
            z_q <= mem_rdata;
        end
        if (wdata_ld) begin
            wdata_q <= wdata_d;
        end
    end

    // output value holds between pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            out_data_q <= '0;
        end else begin
            out_valid_q <= dp_ctrl.out_valid;
            if (dp_ctrl.out_valid) begin
                out_data_q <= out_d;
            end
        end
    end

    assign mem_req = '{addr: mar_q, wdata: wdata_q, we: dp_ctrl.we};
    assign mdr = mdr_q;
    assign out_data = out_data_q;
    assign out_valid = out_valid_q;

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] data_t;
    typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CPU_FIELD_ADDR_WIDTH-1:0] field_addr_t;

    // supported opcodes; the rest are skipped by the core
    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_e;

    typedef struct packed {
        logic        ind;
        field_addr_t addr;
    } operand_field_t;

    // raw opcode bits, since unknown codes must still decode
    typedef struct packed {
        logic [3:0]     opcode;
        operand_field_t x;
        operand_field_t y;
        operand_field_t z;
    } instr_t;

    typedef enum logic [1:0] {
        MAR_SRC_PC,
        MAR_SRC_FIELD,
        MAR_SRC_MDR,
        MAR_SRC_XEA
    } mar_src_e;

    typedef enum logic {
        WDATA_Y,
        WDATA_ALU
    } wdata_src_e;

    typedef enum logic [1:0] {
        OUT_MDR,
        OUT_Y,
        OUT_Z
    } out_src_e;

    // per-cycle commands from the sequencer
    typedef struct packed {
        logic        mar_ld;
        mar_src_e    mar_src;
        field_addr_t field_addr;
        addr_t       pc;
        logic        mdr_ld;
        logic        xea_ld;
        logic        y_ld;
        logic        z_ld;
        alu_op_e     alu_op;
        wdata_src_e  wdata_src;
        out_src_e    out_src;
        logic        we;
        logic        out_valid;
    } dp_ctrl_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  we;
    } mem_req_t;

endpackage

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::data_t     mem_rdata,
    output cpu_pkg::mem_req_t  mem_req,
    output cpu_pkg::data_t     out_data,
    output logic               out_valid,
    output logic               halted,
    output cpu_pkg::addr_t     pc
);

    cpu_pkg::dp_ctrl_t dp_ctrl;
    cpu_pkg::data_t    mdr;

    // sequencer: fetch, operand walk, execute
    cpu_control u_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .mdr     (mdr),
        .dp_ctrl (dp_ctrl),
        .halted  (halted),
        .pc      (pc)
    );

    // registers between core and memory port
    cpu_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .dp_ctrl   (dp_ctrl),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mdr       (mdr),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

/* include/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// memory word and address widths
`define CPU_DATA_WIDTH 16
`define CPU_ADDR_WIDTH 6

// operand fields reach words 0 to 7 only
`define CPU_FIELD_ADDR_WIDTH 3

// first instruction, right above the operand window
`define CPU_RESET_PC 8

// depth of the external memory
`define CPU_MEM_WORDS 64

`endif

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timescale 1ns/100ps --top-module tb_cpu \
    -f all.f -o Vtb_cpu > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_cpu 2>&1 | tee sim.log \
    || echo "simulation process returned an error"
grep -q "^TEST PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/tb_cpu.sv */
`default_nettype none

`include "cpu_config.svh"

module tb_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_PROGRAMS = 8;
    localparam int MAX_PROG_LEN = 31;
    localparam int SETTLE_CYCLES = 8;
    // no instruction needs 20 cycles, margin covers reset and settling
    localparam int WATCHDOG_NS =
        NUM_PROGRAMS * (MAX_PROG_LEN * 20 + RESET_CYCLES + SETTLE_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        cpu_pkg::addr_t addr;
        cpu_pkg::data_t data;
    } write_rec_t;

    logic              clk;
    logic              rst_n;
    logic              load_mem;
    cpu_pkg::data_t    mem_rdata;
    cpu_pkg::mem_req_t mem_req;
    cpu_pkg::data_t    out_data;
    logic              out_valid;
    logic              halted;
    cpu_pkg::addr_t    pc;

    cpu_pkg::data_t mem [0:`CPU_MEM_WORDS-1] = '{default: '0};
    cpu_pkg::data_t init_mem [0:`CPU_MEM_WORDS-1];
    cpu_pkg::data_t model_mem [0:`CPU_MEM_WORDS-1];

    write_rec_t     exp_writes [$];
    cpu_pkg::data_t exp_outs [$];
    cpu_pkg::addr_t exp_halt_pc;
    int             write_idx = 0;
    int             out_idx = 0;
    logic           reset_seen = 1'b0;
    logic           first_cycle = 1'b0;
    logic           fetch_cycle = 1'b0;
    logic           halt_pc_valid = 1'b0;
    cpu_pkg::addr_t halt_pc;
    logic [31:0]    lcg_state = 32'h0f8d_38db;

    cpu_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory model, combinational read and clocked write
    assign mem_rdata = mem[mem_req.addr];

    always @(posedge clk) begin
        if (load_mem) begin
            mem <= init_mem;
        end else if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            stop_on_failure();
        end
    endtask

    function automatic cpu_pkg::addr_t word_addr(input int i);
        return cpu_pkg::addr_t'(i);
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // direct fields use words 0 to 3, indirect ones the pointer words 4 to 7
    function automatic cpu_pkg::operand_field_t random_field();
        logic [31:0] r;
        r = next_random();
        if (r[20]) begin
            return cpu_pkg::operand_field_t'({2'b11, r[17:16]});
        end
        return cpu_pkg::operand_field_t'({2'b00, r[17:16]});
    endfunction

    // a zero address drops the field from the STOP output
    function automatic cpu_pkg::operand_field_t stop_field(input logic force_zero);
        logic [31:0] r;
        r = next_random();
        if (force_zero || (r[31:16] % 16'd3) == 16'd0) begin
            return cpu_pkg::operand_field_t'({r[12], 3'b000});
        end
        return random_field();
    endfunction

    function automatic logic [3:0] random_opcode();
        logic [31:0] r;
        int sel;
        int k;
        r = next_random();
        sel = int'(r[31:16] % 16'd12);
        r = next_random();
        k = int'(r[31:16] % 16'd10);
        case (sel)
            0, 1: return cpu_pkg::OP_MOV;
            2, 3: return cpu_pkg::OP_ADD;
            4, 5: return cpu_pkg::OP_SUB;
            6, 7: return cpu_pkg::OP_MUL;
            8, 9: return cpu_pkg::OP_OUT;
            // unsupported codes 4 to 7 and 9 to 14
            default: return (k < 4) ? 4'(4 + k) : 4'(5 + k);
        endcase
    endfunction

    task automatic build_program(input int prog, output int len);
        int i;
        logic [31:0] r;
        cpu_pkg::instr_t ins;
        for (i = 0; i < `CPU_MEM_WORDS; i++) begin
            init_mem[word_addr(i)] = '0;
        end
        for (i = 0; i < 4; i++) begin
            r = next_random();
            init_mem[word_addr(i)] = r[31:16];
            r = next_random();
            // pointers land in the data area 40 to 63
            init_mem[word_addr(i + 4)] = cpu_pkg::data_t'(32'd40 + (r[31:16] % 32'd24));
        end
        for (i = 40; i < `CPU_MEM_WORDS; i++) begin
            r = next_random();
            init_mem[word_addr(i)] = r[31:16];
        end
        r = next_random();
        len = 4 + int'(r[31:16] % 16'd28);
        for (i = 0; i < len - 1; i++) begin
            ins.opcode = random_opcode();
            ins.x = random_field();
            ins.y = random_field();
            ins.z = random_field();
            init_mem[word_addr(`CPU_RESET_PC + i)] = ins;
        end
        // the STOP of program 1 skips all three fields
        ins.opcode = cpu_pkg::OP_STOP;
        ins.x = stop_field(prog == 1);
        ins.y = stop_field(prog == 1);
        ins.z = stop_field(prog == 1);
        init_mem[word_addr(`CPU_RESET_PC + len - 1)] = ins;
    endtask

    function automatic cpu_pkg::addr_t effective_addr(input cpu_pkg::operand_field_t f);
        cpu_pkg::addr_t direct;
        direct = cpu_pkg::addr_t'(f.addr);
        if (f.ind) begin
            return model_mem[direct][`CPU_ADDR_WIDTH-1:0];
        end
        return direct;
    endfunction

    function automatic cpu_pkg::data_t operand_value(input cpu_pkg::operand_field_t f);
        return model_mem[effective_addr(f)];
    endfunction

    task automatic model_store(input cpu_pkg::addr_t dest, input cpu_pkg::data_t value);
        write_rec_t rec;
        rec.addr = dest;
        rec.data = value;
        model_mem[dest] = value;
        exp_writes.push_back(rec);
    endtask

    // instruction-set model over a copy of the initial memory
    task automatic run_reference();
        cpu_pkg::addr_t  rpc;
        cpu_pkg::instr_t ins;
        cpu_pkg::addr_t  dest;
        logic            running;
        model_mem = init_mem;
        exp_writes.delete();
        exp_outs.delete();
        rpc = cpu_pkg::addr_t'(`CPU_RESET_PC);
        running = 1'b1;
        while (running) begin
            ins = cpu_pkg::instr_t'(model_mem[rpc]);
            rpc = rpc + 1'b1;
            dest = effective_addr(ins.x);
            case (ins.opcode)
                cpu_pkg::OP_MOV: model_store(dest, operand_value(ins.y));
                cpu_pkg::OP_ADD: model_store(dest, operand_value(ins.y) + operand_value(ins.z));
                cpu_pkg::OP_SUB: model_store(dest, operand_value(ins.y) - operand_value(ins.z));
                cpu_pkg::OP_MUL: model_store(dest, operand_value(ins.y) * operand_value(ins.z));
                cpu_pkg::OP_OUT: exp_outs.push_back(operand_value(ins.x));
                cpu_pkg::OP_STOP: begin
                    if (ins.x.addr != '0) begin
                        exp_outs.push_back(operand_value(ins.x));
                    end
                    if (ins.y.addr != '0) begin
                        exp_outs.push_back(operand_value(ins.y));
                    end
                    if (ins.z.addr != '0) begin
                        exp_outs.push_back(operand_value(ins.z));
                    end
                    running = 1'b0;
                end
                default: begin
                    // skipped by the core
                end
            endcase
        end
        // pc stays one past the STOP word
        exp_halt_pc = rpc;
    endtask

    task automatic check_quiet_state();
        check_value("mem_req.we", 32'(mem_req.we), 32'h0);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("halted", 32'(halted), 32'h0);
        check_value("mem_req.addr", 32'(mem_req.addr), `CPU_RESET_PC);
    endtask

    // quiet outputs in reset and right after it, then the first fetch address
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_seen) begin
                check_quiet_state();
            end
            reset_seen <= 1'b1;
            first_cycle <= 1'b1;
            fetch_cycle <= 1'b0;
        end else if (first_cycle) begin
            check_quiet_state();
            first_cycle <= 1'b0;
            fetch_cycle <= 1'b1;
        end else if (fetch_cycle) begin
            // MDR loads from the address the fetch put on the bus
            check_value("mem_req.addr", 32'(mem_req.addr), `CPU_RESET_PC);
            fetch_cycle <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            write_idx <= 0;
        end else if (mem_req.we) begin
            $display("  write mem[%0d] <= %h", mem_req.addr, mem_req.wdata);
            assert (write_idx < exp_writes.size()) else begin
                $display("write pulse %0d has no matching instruction in the model", write_idx);
                stop_on_failure();
            end
            if (write_idx < exp_writes.size()) begin
                check_value("mem_req.addr", 32'(mem_req.addr), 32'(exp_writes[write_idx].addr));
                check_value("mem_req.wdata", 32'(mem_req.wdata),
                            32'(exp_writes[write_idx].data));
            end
            write_idx <= write_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            out_idx <= 0;
        end else if (out_valid) begin
            $display("  out_data = %h", out_data);
            assert (out_idx < exp_outs.size()) else begin
                $display("out_valid pulsed more often than the model produced outputs");
                stop_on_failure();
            end
            if (out_idx < exp_outs.size()) begin
                check_value("out_data", 32'(out_data), 32'(exp_outs[out_idx]));
            end
            out_idx <= out_idx + 1;
        end
    end

    // pc frozen from the first halted cycle on
    always @(posedge clk) begin
        if (!rst_n) begin
            halt_pc_valid <= 1'b0;
        end else if (halted) begin
            if (!halt_pc_valid) begin
                halt_pc <= pc;
                halt_pc_valid <= 1'b1;
            end else begin
                check_value("pc", 32'(pc), 32'(halt_pc));
            end
        end
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else begin
            $display("[FAIL] halted: got %h, expected %h", halted, 1'b1);
            stop_on_failure();
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                                 halted |-> (!mem_req.we && !out_valid))
        else begin
            $display("[FAIL] mem_req.we/out_valid: got %h/%h, expected 0/0",
                     mem_req.we, out_valid);
            stop_on_failure();
        end

    task automatic apply_reset();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b0;
        load_mem = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);
        load_mem = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt();
        @(posedge clk);
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    task automatic check_final_state();
        int i;
        check_value("write pulse count", 32'(write_idx), 32'(exp_writes.size()));
        check_value("out_valid pulse count", 32'(out_idx), 32'(exp_outs.size()));
        check_value("pc", 32'(pc), 32'(exp_halt_pc));
        for (i = 0; i < `CPU_MEM_WORDS; i++) begin
            check_value($sformatf("mem[%0d]", i), 32'(mem[word_addr(i)]),
                        32'(model_mem[word_addr(i)]));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the core never halted", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin
        int prog;
        int len;
        rst_n = 1'b0;
        load_mem = 1'b0;
        for (prog = 0; prog < NUM_PROGRAMS; prog++) begin
            build_program(prog, len);
            run_reference();
            $display("program %0d: %0d words, %0d writes and %0d outputs expected",
                     prog, len, exp_writes.size(), exp_outs.size());
            apply_reset();
            wait_for_halt();
            check_final_state();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
